/* db_ctrl_settings.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// daughterboard control settings: bus
// addresses, readback map, queue depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DB_CTRL_SETTINGS_SVH
`define DB_CTRL_SETTINGS_SVH

`define SR_MISC_OUTS  8'd0   // misc output word.
`define SR_SYNC       8'd1   // any write pulses sync.
`define SR_CLEAR_CMDS 8'd2   // flushes the command queue.
`define SR_SPI        8'd16  // offsets 0 to 2.
`define SR_LEDS       8'd24  // offsets 0 to 4.
`define SR_FP_GPIO    8'd32  // offsets 0 to 4.
`define SR_DB_GPIO    8'd48  // offsets 0 to 4.

// ATR bank register offsets
`define ATR_OFF_IDLE  8'd0
`define ATR_OFF_RX    8'd1
`define ATR_OFF_TX    8'd2
`define ATR_OFF_FDX   8'd3
`define ATR_OFF_DDR   8'd4

`define SPI_OFF_DIV   8'd0   // sclk half period minus one.
`define SPI_OFF_CFG   8'd1   // ce mask and bit count.
`define SPI_OFF_DATA  8'd2   // write starts a transfer.

`define RB_MISC_IO    8'd0
`define RB_SPI        8'd1
`define RB_LEDS       8'd2
`define RB_DB_GPIO    8'd3
`define RB_FP_GPIO    8'd4
`define RB_BAD_DATA   64'h0BADC0DE0BADC0DE

`define CMD_FIFO_DEPTH   16
`define ATR_DEFAULT_DDR  32'hFFFF_FFFF  // all outputs.
`define ATR_DEFAULT_IDLE 32'd0
`define SEN_IDLE         8'hFF

`endif

/* db_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// daughterboard control types: queued
// command entry and ATR state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package db_ctrl_pkg;

  // one timed setting write, 104 bits packed.
  typedef struct packed {
    logic [7:0]  addr;       // setting address.
    logic [31:0] data;       // setting value.
    logic [63:0] exec_time;  // vita time to release at.
  } set_cmd_t;

  // radio activity, encoded as {run_tx, run_rx}.
  typedef enum logic [1:0] {
    ATR_IDLE = 2'b00,
    ATR_RX   = 2'b01,
    ATR_TX   = 2'b10,
    ATR_FDX  = 2'b11
  } atr_state_t;

endpackage

`default_nettype wire

/* timed_cmd_fifo.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// timed command queue: holds setting
// writes until vita time, flush on clear
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "db_ctrl_settings.svh"

module timed_cmd_fifo
  import db_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         arst_n,
  input  wire         set_stb,
  input  wire  [7:0]  set_addr,
  input  wire  [31:0] set_data,
  input  wire  [63:0] set_time,
  input  wire  [63:0] vita_time,
  input  wire         ready,
  output logic        set_stb_t,
  output logic [7:0]  set_addr_t,
  output logic [31:0] set_data_t
);

  localparam int DEPTH = `CMD_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  set_cmd_t       mem [DEPTH];
  set_cmd_t       head;
  logic [PTR_W:0] wr_ptr;  // extra msb tells full from empty.
  logic [PTR_W:0] rd_ptr;
  logic           empty;
  logic           full;
  logic           clear;
  logic           push;
  logic           pop;

  assign clear = set_stb && (set_addr == `SR_CLEAR_CMDS);
  assign push  = set_stb && !clear && !full;
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign head  = mem[rd_ptr[PTR_W-1:0]];

  // head blocks everything behind it until its time comes.
  assign pop = !empty && !clear && ready && (vita_time >= head.exec_time);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[PTR_W-1:0]] <= '{addr: set_addr, data: set_data, exec_time: set_time};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (clear) begin
      wr_ptr <= '0;  // drops all pending entries.
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // released command goes out on the broadcast bus
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      set_stb_t <= 1'b0;
    end else begin
      set_stb_t <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      set_addr_t <= head.addr;
      set_data_t <= head.data;
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    (set_stb && !clear) |-> !full
  ) else $error("timed_cmd_fifo: command dropped, queue full");

  // pending entries never exceed the depth.
  a_occupancy_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    (wr_ptr - rd_ptr) <= (PTR_W+1)'(DEPTH)
  ) else $error("timed_cmd_fifo: occupancy beyond queue depth");

endmodule

`default_nettype wire

/* gpio_atr.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ATR output bank: picks one of four
// state words from run_rx and run_tx
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "db_ctrl_settings.svh"

module gpio_atr
  import db_ctrl_pkg::*;
#(
  parameter logic [7:0] BASE = `SR_FP_GPIO
) (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         set_stb,
  input  wire  [7:0]  set_addr,
  input  wire  [31:0] set_data,
  input  wire         run_rx,
  input  wire         run_tx,
  input  wire  [31:0] gpio_in,
  output logic [31:0] gpio_out,
  output logic [31:0] gpio_ddr,
  output logic [31:0] gpio_readback
);

  localparam logic [7:0] ADDR_IDLE = BASE + `ATR_OFF_IDLE;
  localparam logic [7:0] ADDR_RX   = BASE + `ATR_OFF_RX;
  localparam logic [7:0] ADDR_TX   = BASE + `ATR_OFF_TX;
  localparam logic [7:0] ADDR_FDX  = BASE + `ATR_OFF_FDX;
  localparam logic [7:0] ADDR_DDR  = BASE + `ATR_OFF_DDR;

  logic [31:0] idle_word;
  logic [31:0] rx_word;
  logic [31:0] tx_word;
  logic [31:0] fdx_word;
  logic [31:0] next_out;
  atr_state_t  state;

  assign state = atr_state_t'({run_tx, run_rx});

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idle_word <= `ATR_DEFAULT_IDLE;
      rx_word   <= `ATR_DEFAULT_IDLE;
      tx_word   <= `ATR_DEFAULT_IDLE;
      fdx_word  <= `ATR_DEFAULT_IDLE;
      gpio_ddr  <= `ATR_DEFAULT_DDR;
    end else if (set_stb) begin
      case (set_addr)
        ADDR_IDLE: idle_word <= set_data;
        ADDR_RX:   rx_word   <= set_data;
        ADDR_TX:   tx_word   <= set_data;
        ADDR_FDX:  fdx_word  <= set_data;
        ADDR_DDR:  gpio_ddr  <= set_data;
        default: ;  // outside this bank.
      endcase
    end
  end

  always_comb begin
    unique case (state)
      ATR_IDLE: next_out = idle_word;
      ATR_RX:   next_out = rx_word;
      ATR_TX:   next_out = tx_word;
      ATR_FDX:  next_out = fdx_word;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gpio_out <= `ATR_DEFAULT_IDLE;
    end else begin
      gpio_out <= next_out;  // one cycle after state change.
    end
  end

  always_ff @(posedge clk) begin
    gpio_readback <= gpio_in;  // pins sampled every cycle.
  end

endmodule

`default_nettype wire

/* spi_master.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI master programmed over the
// settings bus, mode 0, MSB first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "db_ctrl_settings.svh"

module spi_master
  import db_ctrl_pkg::*;
#(
  parameter logic [7:0] BASE = `SR_SPI
) (
  input  wire         clk,
  input  wire         arst_n,
  input  wire         set_stb,
  input  wire  [7:0]  set_addr,
  input  wire  [31:0] set_data,
  input  wire         miso,
  output logic [7:0]  sen,
  output logic        sclk,
  output logic        mosi,
  output logic [31:0] readback,
  output logic        ready
);

  localparam logic [7:0] ADDR_DIV  = BASE + `SPI_OFF_DIV;
  localparam logic [7:0] ADDR_CFG  = BASE + `SPI_OFF_CFG;
  localparam logic [7:0] ADDR_DATA = BASE + `SPI_OFF_DATA;

  logic [15:0] divider;
  logic [7:0]  ce_mask;
  logic [5:0]  bit_count;  // 1 to 32.
  logic [15:0] div_cnt;
  logic [5:0]  bits_left;
  logic [31:0] tx_shift;
  logic [31:0] rx_shift;
  logic        busy;
  logic        start;
  logic        tick;

  assign start    = set_stb && (set_addr == ADDR_DATA) && !busy;
  assign tick     = busy && (div_cnt == divider);
  assign ready    = !busy;
  assign readback = rx_shift;  // received bits, right aligned.

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      divider   <= '0;
      ce_mask   <= '0;
      bit_count <= 6'd32;
    end else if (set_stb) begin
      if (set_addr == ADDR_DIV) begin
        divider <= set_data[15:0];
      end
      if (set_addr == ADDR_CFG) begin
        ce_mask   <= set_data[7:0];
        bit_count <= set_data[13:8];
      end
    end
  end

  // sclk toggles on every tick, so a bit takes two ticks
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy      <= 1'b0;
      sen       <= `SEN_IDLE;
      sclk      <= 1'b0;
      mosi      <= 1'b0;
      div_cnt   <= '0;
      bits_left <= '0;
      tx_shift  <= '0;
      rx_shift  <= '0;
    end else if (start) begin
      busy      <= 1'b1;
      sen       <= `SEN_IDLE & ~ce_mask;  // selected enables low.
      sclk      <= 1'b0;
      mosi      <= set_data[31];  // first bit ready before first rise.
      div_cnt   <= '0;
      bits_left <= bit_count;
      tx_shift  <= set_data;
      rx_shift  <= '0;
    end else if (busy) begin
      if (tick) begin
        div_cnt <= '0;
        sclk    <= ~sclk;
        if (!sclk) begin
          rx_shift  <= {rx_shift[30:0], miso};  // rising edge.
          bits_left <= bits_left - 1'b1;
        end else if (bits_left == '0) begin
          busy <= 1'b0;  // last falling edge ends it.
          sen  <= `SEN_IDLE;
          mosi <= 1'b0;
        end else begin
          tx_shift <= {tx_shift[30:0], 1'b0};
          mosi     <= tx_shift[30];  // falling edge.
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  a_sclk_quiet_when_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    ready |=> $stable(sclk)
  ) else $error("spi_master: sclk toggled while idle");

endmodule

`default_nettype wire

/* db_control.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// daughterboard control top: timed
// settings, ATR banks, SPI, readback
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "db_ctrl_settings.svh"

module db_control
  import db_ctrl_pkg::*;
(
  input  wire         clk,
  input  wire         arst_n,
  // radio core side
  input  wire         set_stb,
  input  wire  [7:0]  set_addr,
  input  wire  [31:0] set_data,
  input  wire  [63:0] set_time,
  output logic        rb_stb,
  input  wire  [7:0]  rb_addr,
  output logic [63:0] rb_data,
  input  wire  [63:0] vita_time,
  input  wire         run_rx,
  input  wire         run_tx,
  // front end side
  input  wire  [31:0] misc_ins,
  output logic [31:0] misc_outs,
  output logic        sync,
  output logic [31:0] leds,
  output logic [31:0] fp_gpio_out,
  output logic [31:0] fp_gpio_ddr,
  input  wire  [31:0] fp_gpio_in,
  output logic [31:0] db_gpio_out,
  output logic [31:0] db_gpio_ddr,
  input  wire  [31:0] db_gpio_in,
  output logic [7:0]  sen,
  output logic        sclk,
  output logic        mosi,
  input  wire         miso
);

  logic        set_stb_t;
  logic [7:0]  set_addr_t;
  logic [31:0] set_data_t;
  logic        spi_ready;
  logic [31:0] spi_readback;
  logic [31:0] leds_readback;
  logic [31:0] fp_gpio_readback;
  logic [31:0] db_gpio_readback;

  timed_cmd_fifo cmd_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .set_stb    (set_stb),
    .set_addr   (set_addr),
    .set_data   (set_data),
    .set_time   (set_time),
    .vita_time  (vita_time),
    .ready      (spi_ready),  // hold commands while SPI is busy.
    .set_stb_t  (set_stb_t),
    .set_addr_t (set_addr_t),
    .set_data_t (set_data_t)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      misc_outs <= '0;
      sync      <= 1'b0;
    end else begin
      if (set_stb_t && (set_addr_t == `SR_MISC_OUTS)) begin
        misc_outs <= set_data_t;
      end
      sync <= set_stb_t && (set_addr_t == `SR_SYNC);  // data ignored.
    end
  end

  always_comb begin
    rb_stb = 1'b1;
    case (rb_addr)
      `RB_MISC_IO: rb_data = {misc_ins, misc_outs};
      `RB_SPI: begin
        rb_stb  = spi_ready;
        rb_data = {31'd0, spi_ready, spi_readback};
      end
      `RB_LEDS:    rb_data = {32'd0, leds_readback};
      `RB_DB_GPIO: rb_data = {32'd0, db_gpio_readback};
      `RB_FP_GPIO: rb_data = {32'd0, fp_gpio_readback};
      default:     rb_data = `RB_BAD_DATA;
    endcase
  end

  // LED bank reads back its own outputs.
  gpio_atr #(.BASE(`SR_LEDS)) leds_atr (
    .clk(clk), .arst_n(arst_n),
    .set_stb(set_stb_t), .set_addr(set_addr_t), .set_data(set_data_t),
    .run_rx(run_rx), .run_tx(run_tx), .gpio_in(leds),
    .gpio_out(leds), .gpio_ddr(), .gpio_readback(leds_readback)
  );

  gpio_atr #(.BASE(`SR_FP_GPIO)) fp_gpio_atr (
    .clk(clk), .arst_n(arst_n),
    .set_stb(set_stb_t), .set_addr(set_addr_t), .set_data(set_data_t),
    .run_rx(run_rx), .run_tx(run_tx), .gpio_in(fp_gpio_in),
    .gpio_out(fp_gpio_out), .gpio_ddr(fp_gpio_ddr), .gpio_readback(fp_gpio_readback)
  );

  gpio_atr #(.BASE(`SR_DB_GPIO)) db_gpio_atr (
    .clk(clk), .arst_n(arst_n),
    .set_stb(set_stb_t), .set_addr(set_addr_t), .set_data(set_data_t),
    .run_rx(run_rx), .run_tx(run_tx), .gpio_in(db_gpio_in),
    .gpio_out(db_gpio_out), .gpio_ddr(db_gpio_ddr), .gpio_readback(db_gpio_readback)
  );

  spi_master #(.BASE(`SR_SPI)) spi (
    .clk(clk), .arst_n(arst_n),
    .set_stb(set_stb_t), .set_addr(set_addr_t), .set_data(set_data_t),
    .miso(miso), .sen(sen), .sclk(sclk), .mosi(mosi),
    .readback(spi_readback), .ready(spi_ready)
  );

endmodule

`default_nettype wire

/* tb_db_control.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// daughterboard control testbench: table
// writes, ATR banks, SPI transfer, clear
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "db_ctrl_settings.svh"

module tb_db_control
  import db_ctrl_pkg::*;
();

  localparam int          NROWS         = 8;
  localparam int          SPI_BITS      = 24;
  localparam int          SPI_DIV       = 1;
  localparam logic [7:0]  SPI_MASK      = 8'h05;
  localparam logic [31:0] SPI_WORD      = 32'hC3A5_96E1;
  localparam logic [31:0] SLAVE_PATTERN = 32'h5A3C_E187;
  localparam int          SPI_LEN       = SPI_BITS * 2 * (SPI_DIV + 1) + 8;
  localparam int          ATR_LEN       = 15 * 2 + 24;  // bank writes and state steps.

  logic        clk;
  logic        arst_n;
  logic        set_stb;
  logic [7:0]  set_addr;
  logic [31:0] set_data;
  logic [63:0] set_time;
  logic        rb_stb;
  logic [7:0]  rb_addr;
  logic [63:0] rb_data;
  logic [63:0] vita_time = '0;
  logic        run_rx;
  logic        run_tx;
  logic [31:0] misc_ins;
  logic [31:0] misc_outs;
  logic        sync;
  logic [31:0] leds;
  logic [31:0] fp_gpio_out;
  logic [31:0] fp_gpio_ddr;
  logic [31:0] fp_gpio_in;
  logic [31:0] db_gpio_out;
  logic [31:0] db_gpio_ddr;
  logic [31:0] db_gpio_in;
  logic [7:0]  sen;
  logic        sclk;
  logic        mosi;
  logic        miso = 1'b0;

  // write table, exec_time holds the offset from the issue time.
  set_cmd_t    row_cmd   [NROWS];
  bit          row_issue [NROWS];
  logic [31:0] row_exp   [NROWS];
  int          row_syncs [NROWS];
  int          row_wait  [NROWS];
  int          n_rows      = 0;
  int          wait_sum    = 0;
  integer      seed        = 32'h083edbf0;
  int          errors      = 0;
  int          checks      = 0;
  int          tests       = 0;
  int          passed      = 0;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;

  // SPI slave state
  logic        sclk_q   = 1'b0;
  int          rise_cnt = 0;
  int          cap_bits = 0;
  logic [31:0] cap_word = '0;
  logic [7:0]  sen_seen = 8'hFF;

  db_control UUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    vita_time <= arst_n ? vita_time + 64'd1 : 64'd0;
  end

  // slave shifts out the pattern's low SPI_BITS bits, MSB first.
  always @(posedge clk) begin
    sclk_q <= sclk;
    if (sen == `SEN_IDLE) begin
      rise_cnt <= 0;
      miso     <= SLAVE_PATTERN[SPI_BITS-1];  // first bit ready before select.
    end else begin
      sen_seen <= sen;
      if (sclk && !sclk_q) begin
        cap_word <= {cap_word[30:0], mosi};
        cap_bits <= cap_bits + 1;
        rise_cnt <= rise_cnt + 1;
        if (rise_cnt < SPI_BITS - 1) begin
          miso <= SLAVE_PATTERN[SPI_BITS-2-rise_cnt];  // next bit after the rise.
        end
      end
    end
  end

  initial begin
    @(posedge clk);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("FAIL t=%0t %s: got %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic end_test(input string name, input int errs0);
    tests++;
    if (errors == errs0) begin
      passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, errors - errs0);
    end
  endtask

  function automatic logic [31:0] atr_word(input int bank, input int off);
    return {8'hA0 + 8'(bank), 8'(off), 16'h3C5A ^ 16'(bank * 5 + off)};
  endfunction

  function automatic logic [7:0] bank_base(input int bank);
    return (bank == 0) ? `SR_LEDS : (bank == 1) ? `SR_FP_GPIO : `SR_DB_GPIO;
  endfunction

  task automatic send_cmd(input logic [7:0] addr, input logic [31:0] data,
                          input logic [63:0] offset);
    @(posedge clk);
    set_stb  <= 1'b1;
    set_addr <= addr;
    set_data <= data;
    set_time <= vita_time + offset;
    @(posedge clk);
    set_stb  <= 1'b0;
  endtask

  task automatic read_back(input logic [7:0] addr, input string name, input logic [63:0] want);
    @(posedge clk);
    rb_addr <= addr;
    @(negedge clk);
    compare(name, rb_data, want);
  endtask

  task automatic add_row(input logic [7:0] addr, input logic [31:0] data, input int offset,
                         input bit issue, input logic [31:0] want_outs, input int syncs,
                         input int wait_cyc);
    row_cmd[n_rows].addr      = addr;
    row_cmd[n_rows].data      = data;
    row_cmd[n_rows].exec_time = 64'(offset);
    row_issue[n_rows]         = issue;
    row_exp[n_rows]           = want_outs;
    row_syncs[n_rows]         = syncs;
    row_wait[n_rows]          = wait_cyc;
    wait_sum                  = wait_sum + wait_cyc;
    n_rows++;
  endtask

  task automatic apply_row(input int i);
    int syncs;
    syncs = 0;
    @(posedge clk);
    misc_ins <= $random(seed);
    rb_addr  <= `RB_MISC_IO;
    if (row_issue[i]) begin
      send_cmd(row_cmd[i].addr, row_cmd[i].data, row_cmd[i].exec_time);
    end
    repeat (row_wait[i]) begin
      @(negedge clk);
      if (sync) begin
        syncs++;
      end
    end
    compare("rb_data", rb_data, {misc_ins, row_exp[i]});
    compare("sync pulses", 64'(syncs), 64'(row_syncs[i]));
  endtask

  task automatic run_rows(input int first, input int last, input string name);
    int errs0;
    errs0 = errors;
    for (int i = first; i <= last; i++) begin
      apply_row(i);
    end
    end_test(name, errs0);
  endtask

  task automatic test_reset();
    int errs0;
    errs0 = errors;
    @(negedge clk);
    compare("misc_outs", {32'd0, misc_outs}, 64'd0);
    compare("sync", {63'd0, sync}, 64'd0);
    compare("sen", {56'd0, sen}, {56'd0, `SEN_IDLE});
    compare("sclk", {63'd0, sclk}, 64'd0);
    compare("leds", {32'd0, leds}, 64'd0);
    compare("fp_gpio_ddr", {32'd0, fp_gpio_ddr}, {32'd0, `ATR_DEFAULT_DDR});
    compare("db_gpio_ddr", {32'd0, db_gpio_ddr}, {32'd0, `ATR_DEFAULT_DDR});
    read_back(`RB_SPI, "rb_data spi", {31'd0, 1'b1, 32'd0});
    compare("rb_stb", {63'd0, rb_stb}, 64'd1);
    read_back(8'h7F, "rb_data unmapped", `RB_BAD_DATA);
    end_test("reset values", errs0);
  endtask

  task automatic test_atr();
    int errs0;
    atr_state_t st;
    errs0 = errors;
    @(posedge clk);
    fp_gpio_in <= $random(seed);
    db_gpio_in <= $random(seed);
    for (int b = 0; b < 3; b++) begin
      for (int o = 0; o < 5; o++) begin
        send_cmd(bank_base(b) + 8'(o), atr_word(b, o), 64'd0);
      end
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    compare("fp_gpio_ddr", {32'd0, fp_gpio_ddr}, {32'd0, atr_word(1, 4)});
    compare("db_gpio_ddr", {32'd0, db_gpio_ddr}, {32'd0, atr_word(2, 4)});
    for (int s = 0; s < 4; s++) begin
      st = atr_state_t'(s[1:0]);
      @(posedge clk);
      run_rx <= st[0];
      run_tx <= st[1];
      @(negedge clk);
      @(negedge clk);  // one clock after the DUT sees the state.
      compare("leds", {32'd0, leds}, {32'd0, atr_word(0, int'(st))});
      compare("fp_gpio_out", {32'd0, fp_gpio_out}, {32'd0, atr_word(1, int'(st))});
      compare("db_gpio_out", {32'd0, db_gpio_out}, {32'd0, atr_word(2, int'(st))});
    end
    read_back(`RB_FP_GPIO, "rb_data fp_gpio", {32'd0, fp_gpio_in});
    read_back(`RB_DB_GPIO, "rb_data db_gpio", {32'd0, db_gpio_in});
    read_back(`RB_LEDS, "rb_data leds", {32'd0, atr_word(0, 3)});
    end_test("ATR selection", errs0);
  endtask

  task automatic test_spi();
    int errs0;
    int n;
    logic [31:0] low_mask;
    errs0    = errors;
    low_mask = (32'd1 << SPI_BITS) - 32'd1;
    send_cmd(`SR_SPI + `SPI_OFF_DIV, 32'(SPI_DIV), 64'd0);
    send_cmd(`SR_SPI + `SPI_OFF_CFG, {18'd0, 6'(SPI_BITS), SPI_MASK}, 64'd0);
    @(posedge clk);
    rb_addr <= `RB_SPI;
    send_cmd(`SR_SPI + `SPI_OFF_DATA, SPI_WORD, 64'd0);
    n = 0;
    while (rb_stb && n < 16) begin
      @(negedge clk);
      n++;
    end
    if (rb_stb) begin
      errors++;
      $display("spi transfer never started, rb_stb stayed high");
    end
    n = 0;
    while (!rb_stb && n < SPI_LEN) begin
      @(negedge clk);
      n++;
    end
    if (!rb_stb) begin
      errors++;
      $display("spi transfer still busy after %0d cycles", SPI_LEN);
    end
    @(negedge clk);
    compare("mosi bits", 64'(cap_bits), 64'(SPI_BITS));
    compare("mosi word", {32'd0, cap_word & low_mask}, {32'd0, SPI_WORD >> (32 - SPI_BITS)});
    compare("sen during transfer", {56'd0, sen_seen}, {56'd0, ~SPI_MASK});
    compare("sen", {56'd0, sen}, {56'd0, `SEN_IDLE});
    compare("rb_data spi", rb_data, {31'd0, 1'b1, SLAVE_PATTERN & low_mask});
    end_test("SPI transfer", errs0);
  endtask

  initial begin
    set_stb    = 1'b0;
    set_addr   = '0;
    set_data   = '0;
    set_time   = '0;
    rb_addr    = '0;
    run_rx     = 1'b0;
    run_tx     = 1'b0;
    misc_ins   = $random(seed);
    fp_gpio_in = '0;
    db_gpio_in = '0;
    arst_n     = 1'b0;
    add_row(`SR_MISC_OUTS, 32'hA5A5_0001, 0, 1'b1, 32'hA5A5_0001, 0, 6);
    add_row(`SR_SYNC, 32'h0000_0000, 0, 1'b1, 32'hA5A5_0001, 1, 6);
    add_row(`SR_MISC_OUTS, 32'h1234_5678, 0, 1'b1, 32'h1234_5678, 0, 6);
    add_row(`SR_MISC_OUTS, 32'hC0DE_0003, 50, 1'b1, 32'h1234_5678, 0, 20);  // before its time.
    add_row(`SR_MISC_OUTS, 32'h0000_0000, 0, 1'b0, 32'hC0DE_0003, 0, 40);
    add_row(`SR_MISC_OUTS, 32'hDEAD_0005, 60, 1'b1, 32'hC0DE_0003, 0, 2);
    add_row(`SR_MISC_OUTS, 32'hBEEF_0006, 70, 1'b1, 32'hC0DE_0003, 0, 2);
    add_row(`SR_CLEAR_CMDS, 32'h0000_0000, 0, 1'b1, 32'hC0DE_0003, 0, 80);  // both flushed.
    cycle_limit = 2 * (wait_sum + 3 * NROWS + SPI_LEN + ATR_LEN);
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    test_reset();
    run_rows(0, 2, "immediate writes");
    run_rows(3, 4, "timed write");
    test_atr();
    test_spi();
    run_rows(5, 7, "clear queued writes");
    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             tests, passed, tests - passed, checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
db_ctrl_pkg.sv
timed_cmd_fifo.sv
gpio_atr.sv
spi_master.sv
db_control.sv
tb_db_control.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_db_control
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
